// ==== Makefile ====
# Verilator build and run for the float adder pipeline.
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = fp_adder_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/fp_adder_tb.sv ====
// fp_adder_tb runs a table of float add and subtract vectors through the pipeline in order.
module fp_adder_tb;

    localparam logic [31:0] LFSR_SEED   = 32'd74701;
    localparam logic [31:0] LATENCY     = 32'd4;      // input edge to output edge.
    localparam logic [31:0] OUT_TIMEOUT = 32'd20;     // cycles allowed per result.

    typedef struct packed {
        logic [31:0]        a;
        logic [31:0]        b;
        fp_add_pkg::fp_op_e op;
        logic [31:0]        expected;                 // hand computed result.
    } vector_t;

    typedef struct packed {
        logic [31:0] expected;
        logic [31:0] issue_cycle;                     // cycle the input was driven.
        logic [31:0] index;                           // table entry number.
    } pending_t;

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic [31:0]        a;
    logic [31:0]        b;
    fp_add_pkg::fp_op_e op;
    logic               out_valid;
    logic [31:0]        result;

    vector_t     vectors[$];
    pending_t    pending_q[$];                         // results still in flight.
    logic [31:0] cycle = 32'd0;
    logic [31:0] lfsr;
    int          wait_cycles;

    fp_adder UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .op        (op),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                        // period 100.
    end

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;                        // edge counter.
    end

    // galois lfsr with taps 32 30 26 25.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 32'ha3000000;
        end
        return nxt;
    endfunction

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s is %08h, expected %08h",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic add_vector(input logic [31:0] va, input logic [31:0] vb,
                              input fp_add_pkg::fp_op_e vop, input logic [31:0] vexp);
        vectors.push_back('{va, vb, vop, vexp});
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #5;                                            // drive just after the edge.
    endtask

    task automatic fill_vector_table();
        add_vector(32'h3f800000, 32'h3f800000, fp_add_pkg::OP_ADD, 32'h40000000); // 1+1 carries.
        add_vector(32'h3f800000, 32'h40000000, fp_add_pkg::OP_ADD, 32'h40400000); // gap of 1.
        add_vector(32'h3fc00000, 32'h3fc00000, fp_add_pkg::OP_ADD, 32'h40400000);
        add_vector(32'hbf800000, 32'hc0000000, fp_add_pkg::OP_ADD, 32'hc0400000); // both negative.
        add_vector(32'h40000000, 32'hbf800000, fp_add_pkg::OP_SUB, 32'h40400000); // 2 - (-1).
        add_vector(32'h3f800000, 32'h40400000, fp_add_pkg::OP_SUB, 32'hc0000000); // b larger.
        add_vector(32'h3f800000, 32'h30800000, fp_add_pkg::OP_ADD, 32'h3f800000); // gap 30.
        add_vector(32'h3f800000, 32'h30800000, fp_add_pkg::OP_SUB, 32'h3f800000); // sticky only.
        add_vector(32'hbf800000, 32'h30800000, fp_add_pkg::OP_ADD, 32'hbf800000);
        add_vector(32'h3f800001, 32'h3f800000, fp_add_pkg::OP_SUB, 32'h34000000); // shift 23.
        add_vector(32'h3f800000, 32'h3f7fffff, fp_add_pkg::OP_SUB, 32'h33800000); // shift 24.
        add_vector(32'h3fc00000, 32'h3fc00000, fp_add_pkg::OP_SUB, 32'h00000000); // exact to +0.
        add_vector(32'hbfc00000, 32'h3fc00000, fp_add_pkg::OP_ADD, 32'h00000000);
        add_vector(32'h80000000, 32'h80000000, fp_add_pkg::OP_ADD, 32'h80000000); // -0 + -0.
        add_vector(32'h00000000, 32'h80000000, fp_add_pkg::OP_ADD, 32'h00000000);
        add_vector(32'h80000000, 32'h00000000, fp_add_pkg::OP_SUB, 32'h80000000);
        add_vector(32'h00800001, 32'h00800000, fp_add_pkg::OP_SUB, 32'h00000001); // to denormal.
        add_vector(32'h01000000, 32'h00ffffff, fp_add_pkg::OP_SUB, 32'h00000001); // shift capped.
        add_vector(32'h00c00000, 32'h00800000, fp_add_pkg::OP_SUB, 32'h00400000);
        add_vector(32'h00400000, 32'h00400000, fp_add_pkg::OP_ADD, 32'h00800000); // into normal.
        add_vector(32'h00000001, 32'h00000001, fp_add_pkg::OP_ADD, 32'h00000002);
        add_vector(32'h00800000, 32'h00000001, fp_add_pkg::OP_ADD, 32'h00800001);
        add_vector(32'h3f800000, 32'h33800000, fp_add_pkg::OP_ADD, 32'h3f800000); // even tie.
        add_vector(32'h3f800001, 32'h33800000, fp_add_pkg::OP_ADD, 32'h3f800002); // odd tie up.
        add_vector(32'h3f800000, 32'h33c00000, fp_add_pkg::OP_ADD, 32'h3f800001); // above half.
        add_vector(32'h3f800000, 32'h33000000, fp_add_pkg::OP_ADD, 32'h3f800000); // below half.
        add_vector(32'h3f800001, 32'h3f800002, fp_add_pkg::OP_ADD, 32'h40000002); // carry tie up.
        add_vector(32'h3f800000, 32'h3f800001, fp_add_pkg::OP_ADD, 32'h40000000); // carry tie.
        add_vector(32'h3fffffff, 32'h33800000, fp_add_pkg::OP_ADD, 32'h40000000); // round carry.
        add_vector(32'h7f7fffff, 32'h7f7fffff, fp_add_pkg::OP_ADD, 32'h7f800000); // overflow.
        add_vector(32'h7f7fffff, 32'h73000000, fp_add_pkg::OP_ADD, 32'h7f800000); // round to inf.
        add_vector(32'hff7fffff, 32'hff7fffff, fp_add_pkg::OP_ADD, 32'hff800000);
    endtask

    // result checker samples on the falling edge.
    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid) begin
                if (pending_q.size() == 0) begin
                    $display("out_valid was high at %0t with no operation in flight", $time);
                    stop_with_failure();
                end else begin
                    check_value($sformatf("result of vector %0d", pending_q[0].index),
                                result, pending_q[0].expected);
                    check_value($sformatf("latency of vector %0d", pending_q[0].index),
                                cycle - pending_q[0].issue_cycle, LATENCY);
                    void'(pending_q.pop_front());
                end
            end else if (pending_q.size() != 0 &&
                         (cycle - pending_q[0].issue_cycle) > OUT_TIMEOUT) begin
                $display("timeout: out_valid never came for vector %0d", pending_q[0].index);
                stop_with_failure();
            end
        end
    end

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        a        = 32'd0;
        b        = 32'd0;
        op       = fp_add_pkg::OP_ADD;
        lfsr     = LFSR_SEED;
        fill_vector_table();

        repeat (3) @(posedge clk);                     // reset held 3 cycles.
        #5;
        rst = 1'b0;
        step_cycle();                                  // one quiet cycle first.

        for (int i = 0; i < vectors.size(); i++) begin
            lfsr = lfsr_next(lfsr);
            if (lfsr[0]) begin
                in_valid = 1'b0;                       // random gap.
                step_cycle();
            end
            in_valid = 1'b1;
            a        = vectors[i].a;
            b        = vectors[i].b;
            op       = vectors[i].op;
            pending_q.push_back('{vectors[i].expected, cycle, 32'(i)});
            step_cycle();
        end
        in_valid = 1'b0;

        // drain the pipeline.
        wait_cycles = 0;
        while (pending_q.size() != 0 && wait_cycles < 20) begin
            @(posedge clk);
            wait_cycles++;
        end

        if (pending_q.size() != 0) begin
            $display("timeout: %0d results never appeared on out_valid", pending_q.size());
            stop_with_failure();
        end else begin
            repeat (8) @(posedge clk);                 // out_valid must stay low.
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
source/fp_add_pkg.sv
source/find_first_1.sv
source/fp_align.sv
source/fp_sig_add.sv
source/normalize.sv
source/fp_round_pack.sv
source/fp_adder.sv
dv/fp_adder_tb.sv

// ==== source/find_first_1.sv ====
// find_first_1 is a priority encoder giving the position of the highest set bit.
module find_first_1 #(
    parameter int WIDTH = 32                    // input vector width.
) (
    input  logic [WIDTH-1:0] vec,
    output logic [15:0]      index
);

    // scan upward so the highest one wins.
    // all zeros leaves index at 0.
    always_comb begin
        index = 16'd0;
        for (int i = 0; i < WIDTH; i++) begin
            if (vec[i]) begin
                index = 16'(i);                 // later hits override.
            end
        end
    end

endmodule

// ==== source/fp_add_pkg.sv ====
// fp_add_pkg holds the float format widths, the opcode and the pipeline stage structs.
package fp_add_pkg;

    localparam int EXP_W  = 8;                   // biased exponent bits.
    localparam int FRAC_W = 23;                  // stored fraction bits.
    localparam int SIG_W  = 27;                  // hidden + fraction + guard/round/sticky.

    localparam logic [EXP_W-1:0] EXP_MAX = 8'hff; // all ones, infinity exponent.

    typedef enum logic {
        OP_ADD = 1'b0,                           // a + b.
        OP_SUB = 1'b1                            // a - b.
    } fp_op_e;

    // stage 1 to stage 2.
    typedef struct packed {
        logic             valid;                 // op present.
        logic             sign;                  // sign of larger operand.
        logic             eff_sub;               // signs differ after op.
        logic [EXP_W-1:0] exp;                   // larger exponent, denormal as 1.
        logic [SIG_W-1:0] sig_big;               // larger significand.
        logic [SIG_W-1:0] sig_small;             // shifted smaller significand.
    } aligned_t;

    // stage 2 to stage 3.
    typedef struct packed {
        logic             valid;
        logic             sign;
        logic [EXP_W-1:0] exp;                   // not yet adjusted.
        logic [SIG_W-1:0] sig;                   // raw sum or difference.
        logic             carryout;              // carry out of bit 26.
    } sum_t;

    // stage 3 to stage 4.
    typedef struct packed {
        logic             valid;
        logic             sign;
        logic [EXP_W-1:0] exp;                   // 0 means denormal or zero.
        logic [SIG_W-1:0] sig;                   // hidden bit at 26 when normal.
    } norm_t;

endpackage

// ==== source/fp_adder.sv ====
// fp_adder is a four stage single precision add and subtract pipeline.
module fp_adder (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,        // one strobe per operation.
    input  logic [31:0]        a,
    input  logic [31:0]        b,
    input  fp_add_pkg::fp_op_e op,
    output logic               out_valid,       // four cycles after in_valid.
    output logic [31:0]        result
);

    fp_add_pkg::aligned_t aligned;               // stage 1 out.
    fp_add_pkg::sum_t     sum;                   // stage 2 out.
    fp_add_pkg::norm_t    norm;                  // stage 3 out.

    fp_align u_align (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .op       (op),
        .aligned  (aligned)
    );

    fp_sig_add u_sig_add (
        .clk     (clk),
        .rst     (rst),
        .aligned (aligned),
        .sum     (sum)
    );

    normalize u_normalize (
        .clk  (clk),
        .rst  (rst),
        .sum  (sum),
        .norm (norm)
    );

    fp_round_pack u_round_pack (
        .clk       (clk),
        .rst       (rst),
        .norm      (norm),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

// ==== source/fp_align.sv ====
// fp_align unpacks both operands, orders them by magnitude and aligns the smaller significand.
module fp_align (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic [31:0]          a,
    input  logic [31:0]          b,
    input  fp_add_pkg::fp_op_e   op,
    output fp_add_pkg::aligned_t aligned
);

    logic                              sign_a;
    logic                              sign_b;
    logic [fp_add_pkg::EXP_W-1:0]      exp_a;
    logic [fp_add_pkg::EXP_W-1:0]      exp_b;
    logic [fp_add_pkg::SIG_W-1:0]      sig_a;
    logic [fp_add_pkg::SIG_W-1:0]      sig_b;
    logic                              a_ge_b;
    logic [fp_add_pkg::EXP_W-1:0]      exp_small;
    logic [fp_add_pkg::SIG_W-1:0]      sig_small_raw;
    logic [fp_add_pkg::EXP_W-1:0]      diff;
    logic [fp_add_pkg::SIG_W-1:0]      lost_mask;
    logic [fp_add_pkg::SIG_W-1:0]      sig_shifted;
    fp_add_pkg::aligned_t              aligned_d;

    // unpack both operands.
    always_comb begin
        sign_a = a[31];
        sign_b = b[31] ^ (op == fp_add_pkg::OP_SUB);                 // subtract flips b.
        exp_a  = a[fp_add_pkg::FRAC_W +: fp_add_pkg::EXP_W];
        exp_b  = b[fp_add_pkg::FRAC_W +: fp_add_pkg::EXP_W];
        sig_a  = {(exp_a != '0), a[fp_add_pkg::FRAC_W-1:0], 3'b000}; // hidden bit set if normal.
        sig_b  = {(exp_b != '0), b[fp_add_pkg::FRAC_W-1:0], 3'b000};
        if (exp_a == '0) begin
            exp_a = 8'd1;                                            // denormal scale is 2^-126.
        end
        if (exp_b == '0) begin
            exp_b = 8'd1;
        end
    end

    // order by magnitude and align.
    always_comb begin
        a_ge_b = {exp_a, sig_a} >= {exp_b, sig_b};                   // exponent first then sig.

        aligned_d.valid   = in_valid;
        aligned_d.eff_sub = sign_a ^ sign_b;
        aligned_d.sign    = a_ge_b ? sign_a : sign_b;
        aligned_d.exp     = a_ge_b ? exp_a : exp_b;
        aligned_d.sig_big = a_ge_b ? sig_a : sig_b;
        exp_small         = a_ge_b ? exp_b : exp_a;
        sig_small_raw     = a_ge_b ? sig_b : sig_a;

        diff      = aligned_d.exp - exp_small;                       // never negative.
        lost_mask = ~({fp_add_pkg::SIG_W{1'b1}} << diff);            // bits that fall off.

        if (diff >= 8'(fp_add_pkg::SIG_W)) begin
            sig_shifted    = '0;                                     // only sticky survives.
            sig_shifted[0] = |sig_small_raw;
        end else begin
            sig_shifted    = sig_small_raw >> diff;
            sig_shifted[0] = sig_shifted[0] | (|(sig_small_raw & lost_mask));
        end
        aligned_d.sig_small = sig_shifted;
    end

    always_ff @(posedge clk) begin
        aligned <= aligned_d;
        if (rst) begin
            aligned.valid <= 1'b0;                                   // flush stage.
        end
    end

    // larger operand stays larger after the shift, so stage 2 never borrows.
    big_not_smaller_a : assert property (
        @(posedge clk) disable iff (rst)
        aligned.valid |-> (aligned.sig_big >= aligned.sig_small)
    );

endmodule

// ==== source/fp_round_pack.sv ====
// fp_round_pack rounds to nearest even and packs the single precision result.
module fp_round_pack (
    input  logic              clk,
    input  logic              rst,
    input  fp_add_pkg::norm_t norm,
    output logic              out_valid,
    output logic [31:0]       result
);

    logic                          round_up;
    logic [fp_add_pkg::FRAC_W+1:0] rounded;     // carry, hidden, fraction.
    logic [fp_add_pkg::EXP_W-1:0]  exp_r;
    logic [fp_add_pkg::FRAC_W-1:0] frac_r;
    logic [31:0]                   result_d;

    always_comb begin
        // guard set and anything else set, or a tie on an odd lsb.
        round_up = norm.sig[2] & (norm.sig[1] | norm.sig[0] | norm.sig[3]);
        rounded  = {1'b0, norm.sig[fp_add_pkg::SIG_W-1:3]}
                 + {{(fp_add_pkg::FRAC_W + 1){1'b0}}, round_up};

        if (rounded[fp_add_pkg::FRAC_W+1]) begin
            exp_r  = norm.exp + 8'd1;                        // rounding wrapped to 2.0.
            frac_r = rounded[fp_add_pkg::FRAC_W:1];
        end else if ((norm.exp == '0) && rounded[fp_add_pkg::FRAC_W]) begin
            exp_r  = 8'd1;                                   // denormal grew into normal.
            frac_r = rounded[fp_add_pkg::FRAC_W-1:0];
        end else begin
            exp_r  = norm.exp;
            frac_r = rounded[fp_add_pkg::FRAC_W-1:0];
        end

        if (exp_r == fp_add_pkg::EXP_MAX) begin
            result_d = {norm.sign, fp_add_pkg::EXP_MAX, {fp_add_pkg::FRAC_W{1'b0}}}; // infinity.
        end else begin
            result_d = {norm.sign, exp_r, frac_r};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= norm.valid;                         // one cycle strobe.
        end
    end

    always_ff @(posedge clk) begin
        result <= result_d;
    end

endmodule

// ==== source/fp_sig_add.sv ====
// fp_sig_add adds or subtracts the aligned significands and keeps the carry out.
module fp_sig_add (
    input  logic                 clk,
    input  logic                 rst,
    input  fp_add_pkg::aligned_t aligned,
    output fp_add_pkg::sum_t     sum
);

    logic [fp_add_pkg::SIG_W:0] raw;                        // one extra bit for carry.
    fp_add_pkg::sum_t           sum_d;

    always_comb begin
        if (aligned.eff_sub) begin
            raw = {1'b0, aligned.sig_big} - {1'b0, aligned.sig_small};
        end else begin
            raw = {1'b0, aligned.sig_big} + {1'b0, aligned.sig_small};
        end

        sum_d.valid    = aligned.valid;
        sum_d.exp      = aligned.exp;
        sum_d.sig      = raw[fp_add_pkg::SIG_W-1:0];
        sum_d.carryout = raw[fp_add_pkg::SIG_W];

        // exact cancellation gives +0 under nearest even.
        if (aligned.eff_sub && (raw == '0)) begin
            sum_d.sign = 1'b0;
        end else begin
            sum_d.sign = aligned.sign;                      // -0 + -0 keeps minus.
        end
    end

    always_ff @(posedge clk) begin
        sum <= sum_d;
        if (rst) begin
            sum.valid <= 1'b0;
        end
    end

    // stage 1 ordering means a difference cannot carry.
    no_sub_carry_a : assert property (
        @(posedge clk) disable iff (rst)
        (aligned.valid && aligned.eff_sub) |=> !sum.carryout
    );

endmodule

// ==== source/normalize.sv ====
// normalize shifts the sum so the hidden bit is set and builds denormals when it cannot.
module normalize (
    input  logic              clk,
    input  logic              rst,
    input  fp_add_pkg::sum_t  sum,
    output fp_add_pkg::norm_t norm
);

    logic [15:0]                  first_one;     // highest set bit of sum.
    logic [fp_add_pkg::EXP_W-1:0] lead_shift;    // shift to reach bit 26.
    logic [fp_add_pkg::EXP_W-1:0] max_shift;     // keeps exponent at 1 or above.
    logic [fp_add_pkg::EXP_W-1:0] shift;
    logic [fp_add_pkg::SIG_W-1:0] sig_shifted;
    fp_add_pkg::norm_t            norm_d;

    find_first_1 #(
        .WIDTH (fp_add_pkg::SIG_W)
    ) u_ff1 (
        .vec   (sum.sig),
        .index (first_one)
    );

    always_comb begin
        lead_shift  = 8'(16'(fp_add_pkg::SIG_W - 1) - first_one);
        max_shift   = sum.exp - 8'd1;            // stage 1 exponent is at least 1.
        shift       = (lead_shift > max_shift) ? max_shift : lead_shift;
        sig_shifted = sum.sig << shift;

        norm_d.valid = sum.valid;
        norm_d.sign  = sum.sign;

        if (sum.carryout) begin
            // carry lands at bit 26 and the low two bits fold into sticky.
            norm_d.sig = {1'b1, sum.sig[fp_add_pkg::SIG_W-1:2], sum.sig[1] | sum.sig[0]};
            norm_d.exp = sum.exp + 8'd1;
        end else if (sum.sig == '0) begin
            norm_d.sig = '0;                     // zero result.
            norm_d.exp = '0;
        end else if (lead_shift > max_shift) begin
            norm_d.sig = sig_shifted;            // capped shift leaves a denormal.
            norm_d.exp = '0;
        end else begin
            norm_d.sig = sig_shifted;
            norm_d.exp = sum.exp - shift;
        end
    end

    always_ff @(posedge clk) begin
        norm <= norm_d;
        if (rst) begin
            norm.valid <= 1'b0;
        end
    end

    // every nonzero exponent handed to rounding has its hidden bit.
    hidden_bit_a : assert property (
        @(posedge clk) disable iff (rst)
        sum.valid |=> ((norm.exp == '0) || norm.sig[fp_add_pkg::SIG_W-1])
    );

endmodule
